// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

    typedef struct packed {
        alu_op_t     alu_op;
        wb_sel_t     wb_sel;
        logic        use_imm;
        logic        rf_wen;
        logic        mem_ren;
        logic        mem_wen;
        logic        is_branch;
        logic        branch_ne;
        logic        is_jal;
        logic        is_halt;
        logic [4:0]  rd;
        logic [31:0] imm;
    } ctrl_t;

    // result offered back to decode by a later stage
    typedef struct packed {
        logic        valid;
        logic        can_forward;
        logic [4:0]  rd;
        logic [31:0] wdata;
    } fw_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [15:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        grant;
        logic        rvalid;
        logic [31:0] rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: source/unified_ram.sv
`timescale 1ns/1ps
`default_nettype none

module unified_ram #(
    parameter int ADDR_WORDS = 1024
) (
    input  wire                          clk,
    input  wire                          we,
    input  wire [$clog2(ADDR_WORDS)-1:0] addr,
    input  wire [31:0]                   wdata,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [ADDR_WORDS];

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int ADDR_WORDS = 1024
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire core_pkg::mem_req_t       load_req,
    input  wire core_pkg::mem_req_t       data_req,
    input  wire core_pkg::mem_req_t       fetch_req,
    output core_pkg::mem_resp_t           load_resp,
    output core_pkg::mem_resp_t           data_resp,
    output core_pkg::mem_resp_t           fetch_resp,
    output logic                          ram_we,
    output logic [$clog2(ADDR_WORDS)-1:0] ram_addr,
    output logic [31:0]                   ram_wdata,
    input  wire [31:0]                    ram_rdata
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_LOAD,
        SRC_DATA,
        SRC_FETCH
    } src_t;

    src_t     src;
    src_t     src_q;
    mem_req_t sel;

    // load port first, then data, then fetch
    always_comb begin
        src = SRC_NONE;
        sel = '0;
        if (load_req.req) begin
            src = SRC_LOAD;
            sel = load_req;
        end else if (data_req.req) begin
            src = SRC_DATA;
            sel = data_req;
        end else if (fetch_req.req) begin
            src = SRC_FETCH;
            sel = fetch_req;
        end
    end

    assign ram_we    = sel.req && sel.we;
    assign ram_addr  = sel.addr[$clog2(ADDR_WORDS)-1:0];
    assign ram_wdata = sel.wdata;

    // remembers who owns the data coming out of the RAM next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_q <= SRC_NONE;
        end else begin
            src_q <= src;
        end
    end

    assign load_resp.grant   = (src == SRC_LOAD);
    assign load_resp.rvalid  = (src_q == SRC_LOAD);
    assign load_resp.rdata   = ram_rdata;
    assign data_resp.grant   = (src == SRC_DATA);
    assign data_resp.rvalid  = (src_q == SRC_DATA);
    assign data_resp.rdata   = ram_rdata;
    assign fetch_resp.grant  = (src == SRC_FETCH);
    assign fetch_resp.rvalid = (src_q == SRC_FETCH);
    assign fetch_resp.rdata  = ram_rdata;

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      hold,
    input  wire                      redirect,
    input  wire [31:0]               redirect_pc,
    input  wire                      halted,
    output core_pkg::mem_req_t       mreq,
    input  wire core_pkg::mem_resp_t mresp,
    output logic                     inst_valid,
    output logic [31:0]              inst,
    output logic [31:0]              inst_pc
);

    import core_pkg::*;

    logic [31:0] pc;
    logic        pending;
    logic        stale;
    logic        accept;

    // one fetch in flight, pc stays on it until the word is taken
    assign mreq.req   = !pending && !halted;
    assign mreq.we    = 1'b0;
    assign mreq.addr  = pc[17:2];
    assign mreq.wdata = '0;

    // a word arriving while decode holds is dropped and fetched again
    assign accept = mresp.rvalid && !stale && !redirect && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            pending    <= 1'b0;
            stale      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (mreq.req && mresp.grant) begin
                pending <= 1'b1;
            end else if (mresp.rvalid) begin
                pending <= 1'b0;
            end
            if (redirect) begin
                pc         <= redirect_pc;
                stale      <= mreq.req && mresp.grant;
                inst_valid <= 1'b0;
            end else begin
                if (mresp.rvalid) begin
                    stale <= 1'b0;
                end
                if (accept) begin
                    pc <= pc + 32'd4;
                end
                if (!hold) begin
                    inst_valid <= accept;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst    <= mresp.rdata;
            inst_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire [31:0]          inst,
    input  wire [31:0]          pc,
    input  wire                 valid,
    input  wire [31:0]          rs_data1,
    input  wire [31:0]          rs_data2,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    input  wire core_pkg::fw_t  mem_fw,
    input  wire core_pkg::fw_t  wb_fw,
    output core_pkg::ctrl_t     ctrl,
    output logic [31:0]         op_a,
    output logic [31:0]         op_b,
    output logic                load_use_stall
);

    import core_pkg::*;

    logic        uses_rs1;
    logic        uses_rs2;
    logic [32:0] res1;
    logic [32:0] res2;

    // {cannot forward, value}; mem offer is younger and wins
    function automatic logic [32:0] resolve(input logic [4:0] rs, input logic [31:0] rf_val,
                                            input fw_t m, input fw_t w);
        logic [32:0] r;
        r = {1'b0, rf_val};
        if (rs != 5'd0 && m.valid && m.rd == rs) begin
            r = {!m.can_forward, m.wdata};
        end else if (rs != 5'd0 && w.valid && w.rd == rs) begin
            r = {!w.can_forward, w.wdata};
        end
        return r;
    endfunction

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        ctrl.rd     = inst[11:7];
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b0;
        case (inst[6:0])
            OPC_OP: begin
                ctrl.rf_wen = 1'b1;
                uses_rs2    = 1'b1;
                case (inst[14:12])
                    3'b000:  ctrl.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_LUI: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.imm     = {inst[31:12], 12'b0};
                uses_rs1     = 1'b0;
            end
            OPC_LOAD: begin
                ctrl.rf_wen  = 1'b1;
                ctrl.mem_ren = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.wb_sel  = WB_MEM;
                ctrl.imm     = {{20{inst[31]}}, inst[31:20]};
            end
            OPC_STORE: begin
                ctrl.mem_wen = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                uses_rs2     = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = inst[12];
                ctrl.imm       = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                uses_rs2       = 1'b1;
            end
            OPC_JAL: begin
                ctrl.rf_wen = 1'b1;
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.imm    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                uses_rs1    = 1'b0;
            end
            OPC_SYSTEM: begin
                ctrl.is_halt = 1'b1;
                uses_rs1     = 1'b0;
            end
            default: begin
                uses_rs1 = 1'b0;
            end
        endcase
    end

    assign res1 = resolve(rs1, rs_data1, mem_fw, wb_fw);
    assign res2 = resolve(rs2, rs_data2, mem_fw, wb_fw);

    // pc stands in for rs1 where the instruction reads no register
    assign op_a = uses_rs1 ? res1[31:0] : pc;
    assign op_b = res2[31:0];

    assign load_use_stall = valid && ((uses_rs1 && res1[32]) || (uses_rs2 && res2[32]));

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire core_pkg::ctrl_t ctrl,
    input  wire [31:0]           pc,
    input  wire [31:0]           op_a,
    input  wire [31:0]           op_b,
    input  wire [31:0]           store_data,
    input  wire                  valid,
    output logic [31:0]          alu_out,
    output logic                 redirect,
    output logic [31:0]          target
);

    import core_pkg::*;

    logic [31:0] b;
    logic        taken;

    assign b = ctrl.use_imm ? ctrl.imm : op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + b;
            ALU_SUB:    alu_out = op_a - b;
            ALU_AND:    alu_out = op_a & b;
            ALU_OR:     alu_out = op_a | b;
            ALU_XOR:    alu_out = op_a ^ b;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(b)};
            ALU_PASS_B: alu_out = b;
            default:    alu_out = op_a + b;
        endcase
    end

    // rs2 arrives as store_data, compared here for beq and bne
    assign taken    = ctrl.is_branch && ((op_a == store_data) ^ ctrl.branch_ne);
    assign redirect = valid && (taken || ctrl.is_jal);
    assign target   = pc + ctrl.imm;

endmodule

`default_nettype wire

// File: source/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      valid,
    input  wire core_pkg::ctrl_t     ctrl,
    input  wire [31:0]               addr,
    input  wire [31:0]               wdata,
    output core_pkg::mem_req_t       mreq,
    input  wire core_pkg::mem_resp_t mresp,
    output logic [31:0]              rdata,
    output logic                     busy
);

    import core_pkg::*;

    logic access;
    logic pending;

    assign access = valid && (ctrl.mem_ren || ctrl.mem_wen);

    // request held until granted, then wait for rvalid
    assign mreq.req   = access && !pending;
    assign mreq.we    = ctrl.mem_wen;
    assign mreq.addr  = addr[17:2];
    assign mreq.wdata = wdata;

    assign busy = access && !(pending && mresp.rvalid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (mreq.req && mresp.grant) begin
            pending <= 1'b1;
        end else if (mresp.rvalid) begin
            pending <= 1'b0;
        end
    end

    // load word stays here while the load sits in writeback
    always_ff @(posedge clk) begin
        if (pending && mresp.rvalid && ctrl.mem_ren) begin
            rdata <= mresp.rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  wire                      clk,
    input  wire                      rst_n,
    output core_pkg::mem_req_t       imem_req,
    input  wire core_pkg::mem_resp_t imem_resp,
    output core_pkg::mem_req_t       dmem_req,
    input  wire core_pkg::mem_resp_t dmem_resp,
    output logic                     exit,
    output logic [31:0]              gp
);

    import core_pkg::*;

    logic        f_valid;
    logic [31:0] f_inst;
    logic [31:0] f_pc;
    logic [4:0]  d_rs1;
    logic [4:0]  d_rs2;
    ctrl_t       d_ctrl;
    logic [31:0] d_op_a;
    logic [31:0] d_op_b;
    logic        load_use_stall;
    logic [31:0] regs [32];

    logic        ex_valid;
    ctrl_t       ex_ctrl;
    logic [31:0] ex_pc;
    logic [31:0] ex_op_a;
    logic [31:0] ex_op_b;
    logic [31:0] ex_alu_out;
    logic        ex_redirect;
    logic [31:0] ex_target;

    logic        mem_valid;
    ctrl_t       mem_ctrl;
    logic [31:0] mem_pc;
    logic [31:0] mem_alu;
    logic [31:0] mem_store;
    logic [31:0] mem_rdata;
    logic        mem_busy;

    logic        wb_valid;
    ctrl_t       wb_ctrl;
    logic [31:0] wb_pc;
    logic [31:0] wb_alu;
    logic [31:0] wb_data;

    logic        ex_hazard;
    logic        id_stall;
    logic        redirect;
    fw_t         mem_fw;
    fw_t         wb_fw;

    // nothing forwards out of execute, so a consumer right behind waits a cycle
    assign ex_hazard = f_valid && ex_valid && ex_ctrl.rf_wen && ex_ctrl.rd != 5'd0
                       && (ex_ctrl.rd == d_rs1 || ex_ctrl.rd == d_rs2);
    assign id_stall  = ex_hazard || load_use_stall;
    // a branch waits in execute while memory is busy
    assign redirect  = ex_redirect && !mem_busy;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) i_fetch_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .hold       (mem_busy || id_stall),
        .redirect   (redirect),
        .redirect_pc(ex_target),
        .halted     (exit),
        .mreq       (imem_req),
        .mresp      (imem_resp),
        .inst_valid (f_valid),
        .inst       (f_inst),
        .inst_pc    (f_pc)
    );

    decode_stage i_decode_stage (
        .inst          (f_inst),
        .pc            (f_pc),
        .valid         (f_valid),
        .rs_data1      ((d_rs1 == 5'd0) ? 32'd0 : regs[d_rs1]),
        .rs_data2      ((d_rs2 == 5'd0) ? 32'd0 : regs[d_rs2]),
        .rs1           (d_rs1),
        .rs2           (d_rs2),
        .mem_fw        (mem_fw),
        .wb_fw         (wb_fw),
        .ctrl          (d_ctrl),
        .op_a          (d_op_a),
        .op_b          (d_op_b),
        .load_use_stall(load_use_stall)
    );

    execute_stage i_execute_stage (
        .ctrl      (ex_ctrl),
        .pc        (ex_pc),
        .op_a      (ex_op_a),
        .op_b      (ex_op_b),
        .store_data(ex_op_b),
        .valid     (ex_valid),
        .alu_out   (ex_alu_out),
        .redirect  (ex_redirect),
        .target    (ex_target)
    );

    memory_stage i_memory_stage (
        .clk  (clk),
        .rst_n(rst_n),
        .valid(mem_valid),
        .ctrl (mem_ctrl),
        .addr (mem_alu),
        .wdata(mem_store),
        .mreq (dmem_req),
        .mresp(dmem_resp),
        .rdata(mem_rdata),
        .busy (mem_busy)
    );

    // stage valids and exit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
            exit      <= 1'b0;
        end else begin
            if (!mem_busy) begin
                ex_valid  <= f_valid && !id_stall && !redirect && !exit;
                mem_valid <= ex_valid;
            end
            wb_valid <= mem_valid && !mem_busy;
            if (wb_valid && wb_ctrl.is_halt) begin
                exit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            ex_ctrl   <= d_ctrl;
            ex_pc     <= f_pc;
            ex_op_a   <= d_op_a;
            ex_op_b   <= d_op_b;
            mem_ctrl  <= ex_ctrl;
            mem_pc    <= ex_pc;
            mem_alu   <= ex_alu_out;
            mem_store <= ex_op_b;
            wb_ctrl   <= mem_ctrl;
            wb_pc     <= mem_pc;
            wb_alu    <= mem_alu;
        end
    end

    assign wb_data = (wb_ctrl.wb_sel == WB_MEM) ? mem_rdata :
                     (wb_ctrl.wb_sel == WB_PC4) ? wb_pc + 32'd4 : wb_alu;

    // register file, no writes once halted
    always_ff @(posedge clk) begin
        if (wb_valid && wb_ctrl.rf_wen && wb_ctrl.rd != 5'd0 && !exit) begin
            regs[wb_ctrl.rd] <= wb_data;
        end
    end

    assign gp = regs[3];

    // a load in memory has no value yet
    assign mem_fw.valid       = mem_valid && mem_ctrl.rf_wen;
    assign mem_fw.can_forward = !mem_ctrl.mem_ren;
    assign mem_fw.rd          = mem_ctrl.rd;
    assign mem_fw.wdata       = (mem_ctrl.wb_sel == WB_PC4) ? mem_pc + 32'd4 : mem_alu;

    assign wb_fw.valid       = wb_valid && wb_ctrl.rf_wen;
    assign wb_fw.can_forward = 1'b1;
    assign wb_fw.rd          = wb_ctrl.rd;
    assign wb_fw.wdata       = wb_data;

endmodule

`default_nettype wire

// File: source/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
    parameter int          ADDR_WORDS = 1024,
    parameter logic [31:0] RESET_PC   = 32'h0
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire core_pkg::mem_req_t load_req,
    output core_pkg::mem_resp_t     load_resp,
    output logic                    exit,
    output logic [31:0]             gp
);

    import core_pkg::*;

    mem_req_t                      imem_req;
    mem_resp_t                     imem_resp;
    mem_req_t                      dmem_req;
    mem_resp_t                     dmem_resp;
    logic                          ram_we;
    logic [$clog2(ADDR_WORDS)-1:0] ram_addr;
    logic [31:0]                   ram_wdata;
    logic [31:0]                   ram_rdata;

    pipeline_core #(
        .RESET_PC(RESET_PC)
    ) i_pipeline_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .imem_req (imem_req),
        .imem_resp(imem_resp),
        .dmem_req (dmem_req),
        .dmem_resp(dmem_resp),
        .exit     (exit),
        .gp       (gp)
    );

    mem_arbiter #(
        .ADDR_WORDS(ADDR_WORDS)
    ) i_mem_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .data_req  (dmem_req),
        .fetch_req (imem_req),
        .load_resp (load_resp),
        .data_resp (dmem_resp),
        .fetch_resp(imem_resp),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    unified_ram #(
        .ADDR_WORDS(ADDR_WORDS)
    ) i_unified_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// File: sim/tb_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

    import core_pkg::*;

    localparam int          ADDR_WORDS    = 1024;
    localparam logic [31:0] RESET_PC      = 32'h0;
    localparam int          PROG_BASE     = RESET_PC / 4;
    localparam int          GRANT_TIMEOUT = 20;
    localparam int          EXIT_TIMEOUT  = 2000;

    // register numbers
    localparam logic [4:0] X0 = 5'd0;
    localparam logic [4:0] X1 = 5'd1;
    localparam logic [4:0] X2 = 5'd2;
    localparam logic [4:0] X3 = 5'd3;
    localparam logic [4:0] X4 = 5'd4;
    localparam logic [4:0] X5 = 5'd5;
    localparam logic [4:0] X6 = 5'd6;
    localparam logic [4:0] X7 = 5'd7;

    localparam logic [6:0]  F7_BASE = 7'b0000000;
    localparam logic [6:0]  F7_SUB  = 7'b0100000;
    localparam logic [31:0] ECALL   = 32'h00000073;

    logic        clk;
    logic        rst_n;
    mem_req_t    load_req;
    mem_resp_t   load_resp;
    logic        exit;
    logic [31:0] gp;

    logic [31:0] prog [$];
    integer      seed;
    int          errors;
    int          tests;

    soc_top #(
        .ADDR_WORDS(ADDR_WORDS),
        .RESET_PC  (RESET_PC)
    ) i_soc_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_req (load_req),
        .load_resp(load_resp),
        .exit     (exit),
        .gp       (gp)
    );

    always #4 clk = ~clk;

    // rv32i instruction encoders
    function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // lui rounds up so the sign-extended addi lands on the value
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog.push_back(lui(rd, upper[31:12]));
        prog.push_back(addi(rd, rd, value[11:0]));
    endtask

    task automatic check_equal(input string signal, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("FAIL %s: got %h, expected %h", signal, got, expected);
            errors++;
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst_n    <= 1'b0;
        load_req <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // one word per cycle, the load port outranks fetch
    task automatic load_program();
        int cycles;
        for (int i = 0; i < prog.size(); i++) begin
            load_req.req   <= 1'b1;
            load_req.we    <= 1'b1;
            load_req.addr  <= 16'(PROG_BASE + i);
            load_req.wdata <= prog[i];
            cycles = 0;
            @(posedge clk);
            while (!load_resp.grant && cycles < GRANT_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (!load_resp.grant) begin
                $display("load port was never granted for program word %0d", i);
                errors++;
            end
        end
        load_req <= '0;
    endtask

    // reads each word back, its data shows up the cycle after the grant
    task automatic verify_program();
        for (int i = 0; i <= prog.size(); i++) begin
            if (i < prog.size()) begin
                load_req.req   <= 1'b1;
                load_req.we    <= 1'b0;
                load_req.addr  <= 16'(PROG_BASE + i);
                load_req.wdata <= '0;
            end else begin
                load_req <= '0;
            end
            @(posedge clk);
            if (i < prog.size()) begin
                check_condition(load_resp.grant, "load port read was not granted");
            end
            if (i > 0) begin
                check_condition(load_resp.rvalid, "load port read returned no data");
                check_equal("load_resp.rdata", load_resp.rdata, prog[i - 1]);
            end
        end
    endtask

    task automatic run_program(input string name, input logic [31:0] expected,
                               input int hold_cycles);
        int          errors_before;
        int          cycles;
        logic [31:0] gp_at_exit;
        errors_before = errors;
        tests++;
        reset_core();
        load_program();
        verify_program();
        cycles = 0;
        while (!exit && cycles < EXIT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!exit) begin
            $display("%s: exit did not rise within %0d cycles", name, EXIT_TIMEOUT);
            errors++;
        end else begin
            check_equal("gp", gp, expected);
            gp_at_exit = gp;
            // halted core must stay put
            repeat (hold_cycles) begin
                @(posedge clk);
                check_condition(exit, "exit dropped after the halt");
                check_equal("gp", gp, gp_at_exit);
            end
        end
        $display("test %s: %s", name, (errors == errors_before) ? "pass" : "fail");
    endtask

    // dependent ops back to back, forwarding from mem and wb
    task automatic alu_chain();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] r;
        logic [31:0] t;
        logic [31:0] s;
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        prog.delete();
        load_const(X1, a);
        load_const(X2, b);
        load_const(X4, c);
        prog.push_back(alu_rr(F7_BASE, 3'b000, X3, X1, X2));
        prog.push_back(alu_rr(F7_SUB, 3'b000, X3, X3, X4));
        prog.push_back(alu_rr(F7_BASE, 3'b100, X3, X3, X1));
        prog.push_back(alu_rr(F7_BASE, 3'b111, X6, X3, X2));
        prog.push_back(alu_rr(F7_BASE, 3'b110, X3, X6, X1));
        prog.push_back(alu_rr(F7_BASE, 3'b010, X7, X3, X4));
        prog.push_back(alu_rr(F7_BASE, 3'b000, X3, X3, X7));
        prog.push_back(ECALL);
        r = a + b;
        r = r - c;
        r = r ^ a;
        t = r & b;
        r = t | a;
        s = ($signed(r) < $signed(c)) ? 32'd1 : 32'd0;
        r = r + s;
        run_program("alu_chain", r, 4);
    endtask

    task automatic load_store();
        logic [31:0] v;
        v = $random(seed);
        prog.delete();
        load_const(X5, 32'h0000_0c00);
        load_const(X1, v);
        prog.push_back(sw(X1, X5, 12'h000));
        prog.push_back(lw(X3, X5, 12'h000));
        prog.push_back(addi(X3, X3, 12'h001));
        prog.push_back(ECALL);
        run_program("load_store", v + 32'd1, 4);
    endtask

    // each branch skips two marker adds when taken
    task automatic branch_paths();
        logic [31:0] a;
        logic [31:0] a_copy;
        logic [31:0] d;
        logic [31:0] b;
        logic [31:0] expected;
        a      = $random(seed);
        d      = $random(seed);
        a_copy = a;
        b      = a ^ {d[31:1], 1'b1};
        prog.delete();
        prog.push_back(addi(X3, X0, 12'h000));
        load_const(X1, a);
        load_const(X2, a_copy);
        load_const(X4, b);
        prog.push_back(branch(3'b000, X1, X2, 13'd12));
        prog.push_back(addi(X3, X3, 12'h100));
        prog.push_back(addi(X3, X3, 12'h200));
        prog.push_back(addi(X3, X3, 12'h001));
        prog.push_back(branch(3'b001, X1, X2, 13'd12));
        prog.push_back(addi(X3, X3, 12'h002));
        prog.push_back(addi(X3, X3, 12'h004));
        prog.push_back(branch(3'b000, X1, X4, 13'd12));
        prog.push_back(addi(X3, X3, 12'h008));
        prog.push_back(addi(X3, X3, 12'h010));
        prog.push_back(branch(3'b001, X1, X4, 13'd12));
        prog.push_back(addi(X3, X3, 12'h400));
        prog.push_back(addi(X3, X3, 12'h040));
        prog.push_back(addi(X3, X3, 12'h020));
        prog.push_back(ECALL);
        expected = 32'd0;
        expected = expected + ((a == a_copy) ? 32'd0 : 32'h300) + 32'd1;
        expected = expected + ((a != a_copy) ? 32'd0 : 32'h006);
        expected = expected + ((a == b) ? 32'd0 : 32'h018);
        expected = expected + ((a != b) ? 32'd0 : 32'h440) + 32'h020;
        run_program("branch_paths", expected, 4);
    endtask

    task automatic jal_link();
        int          jal_index;
        logic [31:0] link;
        prog.delete();
        prog.push_back(addi(X3, X0, 12'h7ff));
        prog.push_back(addi(X1, X0, 12'h005));
        jal_index = prog.size();
        prog.push_back(jal(X3, 21'd12));
        prog.push_back(addi(X3, X0, 12'h100));
        prog.push_back(addi(X1, X0, 12'h055));
        prog.push_back(alu_rr(F7_BASE, 3'b000, X3, X3, X1));
        prog.push_back(ECALL);
        link = RESET_PC + 32'(4 * jal_index) + 32'd4;
        run_program("jal_link", link + 32'd5, 4);
    endtask

    // everything after ecall would change gp if it retired
    task automatic halt_hold();
        logic [31:0] v;
        v = $random(seed);
        prog.delete();
        load_const(X3, v);
        prog.push_back(ECALL);
        prog.push_back(addi(X3, X3, 12'h001));
        prog.push_back(lui(X3, 20'habcde));
        prog.push_back(addi(X3, X0, 12'h123));
        prog.push_back(jal(X3, 21'd8));
        prog.push_back(ECALL);
        run_program("halt_hold", v, 20);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        load_req = '0;
        seed     = 49;
        errors   = 0;
        tests    = 0;
        alu_chain();
        load_store();
        branch_paths();
        jal_link();
        halt_hold();
        $display("%0d tests run, %0d checks failed", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
source/core_pkg.sv
source/unified_ram.sv
source/mem_arbiter.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/pipeline_core.sv
source/soc_top.sv
sim/tb_soc.sv

// File: Makefile
# Verilator build and run for the pipeline SoC testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module tb_soc

# pass or fail is decided by the testbench's closing message
run: build
	@out="$$(./obj_dir/Vtb_soc)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tb_soc

clean:
	rm -rf obj_dir
